// File: logic/rv_pkg.sv
// ##################################################
// shared types and encodings for the integer core
// only the RV32I ALU subset listed below is decoded
// ##################################################

package rv_pkg;

  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [3:0]  alu_op_t;
  typedef logic        fwd_sel_t;

  // alu operations
  localparam alu_op_t ALU_ADD  = 4'd0;
  localparam alu_op_t ALU_SUB  = 4'd1;
  localparam alu_op_t ALU_AND  = 4'd2;
  localparam alu_op_t ALU_OR   = 4'd3;
  localparam alu_op_t ALU_XOR  = 4'd4;
  localparam alu_op_t ALU_SLT  = 4'd5;
  localparam alu_op_t ALU_SLL  = 4'd6;
  localparam alu_op_t ALU_SRL  = 4'd7;
  localparam alu_op_t ALU_PASS = 4'd8;

  // operand source
  localparam fwd_sel_t FWD_REG = 1'b0;
  localparam fwd_sel_t FWD_WB  = 1'b1;

  localparam logic [6:0] OPCODE_OP     = 7'b0110011;
  localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPCODE_LUI    = 7'b0110111;

  localparam int NUM_REGS = 32;

endpackage

// File: logic/decode_bus_if.sv
// ##################################################
// registered decode result, one instruction wide
// ##################################################

`timescale 1ns/10ps

interface decode_bus_if #(
  parameter int XLEN = 32
);
  logic               valid_in;
  logic               illegal;
  rv_pkg::alu_op_t    alu_op;
  logic               use_imm;
  logic [XLEN-1:0]    imm;
  rv_pkg::reg_addr_t  rs1;
  rv_pkg::reg_addr_t  rs2;
  rv_pkg::reg_addr_t  rd;
  logic [XLEN-1:0]    rs1_data;
  logic [XLEN-1:0]    rs2_data;

  modport decoder (output valid_in, illegal, alu_op, use_imm, imm, rs1, rs2, rd,
                   rs1_data, rs2_data);
  modport execute (input valid_in, illegal, alu_op, use_imm, imm, rs1, rs2, rd,
                   rs1_data, rs2_data);
  modport control (input rs1, rs2, illegal);
endinterface

// File: logic/writeback_if.sv
// ##################################################
// writeback register, also the commit record
// ##################################################

`timescale 1ns/10ps

interface writeback_if #(
  parameter int XLEN = 32
);
  logic               valid;
  rv_pkg::reg_addr_t  rd;
  logic [XLEN-1:0]    data;

  modport execute (output rd, data);
  modport control (output valid, input rd);
  modport regfile (input valid, rd, data);
endinterface

// File: logic/pipe_control.sv
// ##################################################
// stage valid bits and forwarding selects
// no stalls, every stage accepts each cycle
// ##################################################

`timescale 1ns/10ps

module pipe_control (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   inst_valid,
  decode_bus_if.control          dec,
  writeback_if.control           wb,
  output rv_pkg::fwd_sel_t       fwd_a,
  output rv_pkg::fwd_sel_t       fwd_b
);

  logic fetch_valid;
  logic decode_valid;
  logic wb_hit_a;
  logic wb_hit_b;

  always_ff @(posedge clock) begin
    if (reset) begin
      fetch_valid  <= 1'b0;
      decode_valid <= 1'b0;
      wb.valid     <= 1'b0;
    end else begin
      fetch_valid  <= inst_valid;
      decode_valid <= fetch_valid;
      // illegal instructions die here, never commit
      wb.valid     <= decode_valid & ~dec.illegal;
    end
  end

  // producer one slot ahead sits in the writeback register
  assign wb_hit_a = wb.valid && (wb.rd != '0) && (wb.rd == dec.rs1);
  assign wb_hit_b = wb.valid && (wb.rd != '0) && (wb.rd == dec.rs2);

  assign fwd_a = wb_hit_a ? rv_pkg::FWD_WB : rv_pkg::FWD_REG;
  assign fwd_b = wb_hit_b ? rv_pkg::FWD_WB : rv_pkg::FWD_REG;

endmodule

// File: logic/decoder.sv
// ##################################################
// fetch and decode registers
// unsupported encodings are flagged illegal
// ##################################################

`timescale 1ns/10ps

module decoder #(
  parameter int XLEN = 32
) (
  input  logic                clock,
  input  logic                reset,
  input  rv_pkg::inst_t       inst,
  input  logic                inst_valid,
  output rv_pkg::reg_addr_t   rs1_addr,
  output rv_pkg::reg_addr_t   rs2_addr,
  input  logic [XLEN-1:0]     rs1_data,
  input  logic [XLEN-1:0]     rs2_data,
  decode_bus_if.decoder       dec
);

  rv_pkg::inst_t    fetch_inst;
  logic             fetch_valid;
  logic [6:0]       opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  rv_pkg::alu_op_t  alu_op;
  logic             illegal;
  logic             use_imm;
  logic [XLEN-1:0]  imm;

  always_ff @(posedge clock) begin
    if (reset) begin
      fetch_inst  <= '0;
      fetch_valid <= 1'b0;
    end else begin
      fetch_inst  <= inst;
      fetch_valid <= inst_valid;
    end
  end

  assign opcode   = fetch_inst[6:0];
  assign funct3   = fetch_inst[14:12];
  assign funct7   = fetch_inst[31:25];
  assign rs1_addr = fetch_inst[19:15];
  assign rs2_addr = fetch_inst[24:20];

  always_comb begin
    alu_op  = rv_pkg::ALU_ADD;
    illegal = 1'b0;
    use_imm = 1'b0;
    imm     = XLEN'($signed(fetch_inst[31:20]));
    case (opcode)
      rv_pkg::OPCODE_OP: begin
        case ({funct7, funct3})
          10'b0000000_000: alu_op = rv_pkg::ALU_ADD;
          10'b0100000_000: alu_op = rv_pkg::ALU_SUB;
          10'b0000000_111: alu_op = rv_pkg::ALU_AND;
          10'b0000000_110: alu_op = rv_pkg::ALU_OR;
          10'b0000000_100: alu_op = rv_pkg::ALU_XOR;
          10'b0000000_010: alu_op = rv_pkg::ALU_SLT;
          10'b0000000_001: alu_op = rv_pkg::ALU_SLL;
          10'b0000000_101: alu_op = rv_pkg::ALU_SRL;
          default:         illegal = 1'b1;
        endcase
      end
      rv_pkg::OPCODE_OP_IMM: begin
        use_imm = 1'b1;
        case (funct3)
          3'b000:  alu_op = rv_pkg::ALU_ADD;
          3'b111:  alu_op = rv_pkg::ALU_AND;
          3'b110:  alu_op = rv_pkg::ALU_OR;
          3'b100:  alu_op = rv_pkg::ALU_XOR;
          3'b010:  alu_op = rv_pkg::ALU_SLT;
          // shift immediates are not supported
          default: illegal = 1'b1;
        endcase
      end
      rv_pkg::OPCODE_LUI: begin
        use_imm = 1'b1;
        alu_op  = rv_pkg::ALU_PASS;
        imm     = XLEN'($signed({fetch_inst[31:12], 12'b0}));
      end
      default: illegal = 1'b1;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      dec.valid_in <= 1'b0;
      dec.illegal  <= 1'b0;
      dec.alu_op   <= rv_pkg::ALU_ADD;
      dec.use_imm  <= 1'b0;
      dec.imm      <= '0;
      dec.rs1      <= '0;
      dec.rs2      <= '0;
      dec.rd       <= '0;
      dec.rs1_data <= '0;
      dec.rs2_data <= '0;
    end else begin
      dec.valid_in <= fetch_valid;
      dec.illegal  <= illegal;
      dec.alu_op   <= alu_op;
      dec.use_imm  <= use_imm;
      dec.imm      <= imm;
      dec.rs1      <= rs1_addr;
      dec.rs2      <= rs2_addr;
      dec.rd       <= fetch_inst[11:7];
      dec.rs1_data <= rs1_data;
      dec.rs2_data <= rs2_data;
    end
  end

endmodule

// File: logic/regfile.sv
// ##################################################
// x0 reads zero, writes to it are dropped
// reads see a same-cycle write
// ##################################################

`timescale 1ns/10ps

module regfile #(
  parameter int XLEN = 32
) (
  input  logic               clock,
  input  logic               reset,
  input  rv_pkg::reg_addr_t  rs1_addr,
  input  rv_pkg::reg_addr_t  rs2_addr,
  output logic [XLEN-1:0]    rs1_data,
  output logic [XLEN-1:0]    rs2_data,
  writeback_if.regfile       wb
);

  logic [XLEN-1:0] regs [rv_pkg::NUM_REGS];
  logic            wr_en;

  assign wr_en = wb.valid && (wb.rd != '0);

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < rv_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // bypass covers the producer two slots ahead
  assign rs1_data = (rs1_addr == '0)                  ? '0 :
                    (wr_en && (wb.rd == rs1_addr))    ? wb.data : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0)                  ? '0 :
                    (wr_en && (wb.rd == rs2_addr))    ? wb.data : regs[rs2_addr];

endmodule

// File: logic/execute_unit.sv
// ##################################################
// operand muxes, ALU and the writeback register
// shift amount is 5 bits at XLEN 32, 6 at XLEN 64
// ##################################################

`timescale 1ns/10ps

module execute_unit #(
  parameter int XLEN = 32
) (
  input  logic              clock,
  input  logic              reset,
  decode_bus_if.execute     dec,
  input  rv_pkg::fwd_sel_t  fwd_a,
  input  rv_pkg::fwd_sel_t  fwd_b,
  writeback_if.execute      wb
);

  localparam int SHAMT_W = (XLEN == 64) ? 6 : 5;

  logic [XLEN-1:0]    op_a;
  logic [XLEN-1:0]    rs2_val;
  logic [XLEN-1:0]    op_b;
  logic [SHAMT_W-1:0] shamt;
  logic [XLEN-1:0]    result;

  // wb.data still holds the previous instruction's result here
  assign op_a    = (fwd_a == rv_pkg::FWD_WB) ? wb.data : dec.rs1_data;
  assign rs2_val = (fwd_b == rv_pkg::FWD_WB) ? wb.data : dec.rs2_data;
  assign op_b    = dec.use_imm ? dec.imm : rs2_val;
  assign shamt   = op_b[SHAMT_W-1:0];

  always_comb begin
    case (dec.alu_op)
      rv_pkg::ALU_ADD:  result = op_a + op_b;
      rv_pkg::ALU_SUB:  result = op_a - op_b;
      rv_pkg::ALU_AND:  result = op_a & op_b;
      rv_pkg::ALU_OR:   result = op_a | op_b;
      rv_pkg::ALU_XOR:  result = op_a ^ op_b;
      rv_pkg::ALU_SLT:  result = XLEN'($signed(op_a) < $signed(op_b));
      rv_pkg::ALU_SLL:  result = op_a << shamt;
      rv_pkg::ALU_SRL:  result = op_a >> shamt;
      rv_pkg::ALU_PASS: result = op_b;
      default:          result = '0;
    endcase
  end

  // bubbles leave the last result in place for forwarding
  always_ff @(posedge clock) begin
    if (reset) begin
      wb.rd   <= '0;
      wb.data <= '0;
    end else if (dec.valid_in && !dec.illegal) begin
      wb.rd   <= dec.rd;
      wb.data <= result;
    end
  end

endmodule

// File: logic/core_top.sv
// ##################################################
// three-stage integer core, one instruction per cycle
// commit follows the sampled inst by three edges
// ##################################################

`timescale 1ns/10ps

module core_top #(
  parameter int XLEN = 32
) (
  input  logic               clock,
  input  logic               reset,
  input  logic               inst_valid,
  input  rv_pkg::inst_t      inst,
  output logic               commit_valid,
  output rv_pkg::reg_addr_t  commit_rd,
  output logic [XLEN-1:0]    commit_data
);

  rv_pkg::reg_addr_t rs1_addr;
  rv_pkg::reg_addr_t rs2_addr;
  logic [XLEN-1:0]   rs1_data;
  logic [XLEN-1:0]   rs2_data;
  rv_pkg::fwd_sel_t  fwd_a;
  rv_pkg::fwd_sel_t  fwd_b;

  decode_bus_if #(.XLEN(XLEN)) dec_bus ();
  writeback_if  #(.XLEN(XLEN)) wb_bus ();

  pipe_control u_pipe_control (
    .clock      (clock),
    .reset      (reset),
    .inst_valid (inst_valid),
    .dec        (dec_bus.control),
    .wb         (wb_bus.control),
    .fwd_a      (fwd_a),
    .fwd_b      (fwd_b)
  );

  decoder #(.XLEN(XLEN)) u_decoder (
    .clock      (clock),
    .reset      (reset),
    .inst       (inst),
    .inst_valid (inst_valid),
    .rs1_addr   (rs1_addr),
    .rs2_addr   (rs2_addr),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .dec        (dec_bus.decoder)
  );

  regfile #(.XLEN(XLEN)) u_regfile (
    .clock    (clock),
    .reset    (reset),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb       (wb_bus.regfile)
  );

  execute_unit #(.XLEN(XLEN)) u_execute_unit (
    .clock (clock),
    .reset (reset),
    .dec   (dec_bus.execute),
    .fwd_a (fwd_a),
    .fwd_b (fwd_b),
    .wb    (wb_bus.execute)
  );

  // commit record is the writeback register
  assign commit_valid = wb_bus.valid;
  assign commit_rd    = wb_bus.rd;
  assign commit_data  = wb_bus.data;

endmodule

// File: testbench/core_props.sv
// ##################################################
// pipeline timing properties, bound into core_top
// ##################################################

`timescale 1ns/10ps

module core_props (
  input logic clock,
  input logic reset,
  input logic inst_valid,
  input logic commit_valid
);

  // nothing can reach writeback before three edges have passed
  a_quiet_after_reset: assert property (@(posedge clock)
    commit_valid |-> !reset && !$past(reset) && !$past(reset, 2) && !$past(reset, 3))
    else $error("commit valid seen during reset or within 3 cycles after it");

  a_commit_has_source: assert property (@(posedge clock) disable iff (reset)
    commit_valid |-> $past(inst_valid, 3))
    else $error("commit without an instruction 3 cycles earlier");

endmodule

bind core_top core_props u_core_props (
  .clock        (clock),
  .reset        (reset),
  .inst_valid   (inst_valid),
  .commit_valid (commit_valid)
);

// File: testbench/commit_checker.sv
// ##################################################
// compares commits in order against flagged records
// records with flag 0 are expected never to commit
// ##################################################

`timescale 1ns/10ps

module commit_checker #(
  parameter int XLEN = 32
) (
  input  logic               clock,
  input  logic               reset,
  input  logic               commit_valid,
  input  rv_pkg::reg_addr_t  commit_rd,
  input  logic [XLEN-1:0]    commit_data,
  output int                 done_count,
  output int                 expected_count,
  output int                 error_count
);

  rv_pkg::reg_addr_t exp_rd[$];
  logic [XLEN-1:0]   exp_data[$];
  int                seen = 0;
  int                bad = 0;
  int                file_bad = 0;
  int                n_expected = 0;

  initial begin
    int              fd;
    int              fields;
    logic [31:0]     word;
    logic [3:0]      flag;
    logic [7:0]      rd_val;
    logic [XLEN-1:0] result;
    fd = $fopen("testbench/core_stimulus.txt", "r");
    if (fd == 0) begin
      $display("checker cannot open testbench/core_stimulus.txt");
      file_bad = 1;
    end else begin
      while (!$feof(fd)) begin
        fields = $fscanf(fd, "%h %h %h %h\n", word, flag, rd_val, result);
        if (fields != 4) begin
          break;
        end
        // only records that should commit
        if (flag == 4'd1) begin
          exp_rd.push_back(rd_val[4:0]);
          exp_data.push_back(result);
        end
      end
      $fclose(fd);
    end
    n_expected = exp_rd.size();
  end

  always @(posedge clock) begin
    if (!reset && commit_valid) begin
      if (seen >= n_expected) begin
        $display("unexpected commit at %0t beyond the %0d expected, rd %0d data %h",
                 $time, n_expected, commit_rd, commit_data);
        bad <= bad + 1;
      end else if (commit_rd !== exp_rd[seen] || commit_data !== exp_data[seen]) begin
        $display("MISMATCH at %0t: commit %0d got rd %0d data %h, expected rd %0d data %h",
                 $time, seen, commit_rd, commit_data, exp_rd[seen], exp_data[seen]);
        bad <= bad + 1;
      end
      seen <= seen + 1;
    end
  end

  assign done_count     = seen;
  assign expected_count = n_expected;
  assign error_count    = bad + file_bad;

endmodule

// File: testbench/core_tb.sv
// ##################################################
// feeds the core from the stimulus file
// zero to two idle cycles before each instruction
// ##################################################

`timescale 1ns/10ps

module core_tb;

  localparam int XLEN         = 32;
  localparam int DONE_TIMEOUT = 200;

  logic              clock = 1'b0;
  logic              reset;
  logic              inst_valid;
  rv_pkg::inst_t     inst;
  logic              commit_valid;
  rv_pkg::reg_addr_t commit_rd;
  logic [XLEN-1:0]   commit_data;

  int            done_count;
  int            expected_count;
  int            checker_errors;
  int            tb_errors;
  int            seed;
  rv_pkg::inst_t inst_q[$];

  core_top #(.XLEN(XLEN)) u_core_top (
    .clock        (clock),
    .reset        (reset),
    .inst_valid   (inst_valid),
    .inst         (inst),
    .commit_valid (commit_valid),
    .commit_rd    (commit_rd),
    .commit_data  (commit_data)
  );

  commit_checker #(.XLEN(XLEN)) u_commit_checker (
    .clock          (clock),
    .reset          (reset),
    .commit_valid   (commit_valid),
    .commit_rd      (commit_rd),
    .commit_data    (commit_data),
    .done_count     (done_count),
    .expected_count (expected_count),
    .error_count    (checker_errors)
  );

  always #20 clock = ~clock;

  task automatic load_program();
    int          fd;
    int          fields;
    logic [31:0] word;
    logic [3:0]  flag;
    logic [7:0]  rd_val;
    logic [31:0] result;
    fd = $fopen("testbench/core_stimulus.txt", "r");
    if (fd == 0) begin
      $display("cannot open testbench/core_stimulus.txt");
      tb_errors++;
    end else begin
      while (!$feof(fd)) begin
        fields = $fscanf(fd, "%h %h %h %h\n", word, flag, rd_val, result);
        if (fields != 4) begin
          break;
        end
        inst_q.push_back(word);
      end
      $fclose(fd);
    end
  endtask

  task automatic issue_instruction(input rv_pkg::inst_t word);
    int gap;
    gap = $unsigned($random(seed)) % 3;
    repeat (gap) begin
      @(posedge clock);
      inst_valid <= 1'b0;
    end
    @(posedge clock);
    inst       <= word;
    inst_valid <= 1'b1;
  endtask

  task automatic wait_for_commits();
    int cycles;
    cycles = 0;
    while (done_count < expected_count && cycles < DONE_TIMEOUT) begin
      @(posedge clock);
      cycles++;
    end
    if (done_count < expected_count) begin
      $display("timeout after %0d cycles, only %0d of %0d commits seen",
               cycles, done_count, expected_count);
      tb_errors++;
    end
  endtask

  initial begin
    reset      = 1'b1;
    inst_valid = 1'b0;
    inst       = '0;
    tb_errors  = 0;
    seed       = 32'hd2403bf7;
    load_program();
    if (inst_q.size() == 0) begin
      $display("stimulus file holds no instructions");
      tb_errors++;
    end
    repeat (4) @(posedge clock);
    reset <= 1'b0;
    foreach (inst_q[i]) begin
      issue_instruction(inst_q[i]);
    end
    @(posedge clock);
    inst_valid <= 1'b0;
    wait_for_commits();
    // a few more edges to catch stray commits
    repeat (6) @(posedge clock);
    if (done_count < expected_count) begin
      $display("commit list left unfinished, %0d of %0d seen", done_count, expected_count);
    end
    $display("errors: checker %0d, testbench %0d", checker_errors, tb_errors);
    if (checker_errors == 0 && tb_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: testbench/core_stimulus.txt
00500093 1 01 00000005
FFD00113 1 02 FFFFFFFD
002081B3 1 03 00000002
40208233 1 04 00000008
001122B3 1 05 00000001
00309333 1 06 00000014
004153B3 1 07 00FFFFFF
12345437 1 08 12345000
0F046493 1 09 123450F0
FFF4C513 1 0A EDCBAF0F
7FF57593 1 0B 0000070F
00708013 1 00 0000000C
00B00633 1 0C 0000070F
000000FF 0 01 00000000
0060A693 1 0D 00000001
00A27733 1 0E 00000008
00E6E7B3 1 0F 00000009
0017C833 1 10 0000000C

// File: vlog.f
logic/rv_pkg.sv
logic/decode_bus_if.sv
logic/writeback_if.sv
logic/pipe_control.sv
logic/decoder.sv
logic/regfile.sv
logic/execute_unit.sv
logic/core_top.sv
testbench/core_props.sv
testbench/commit_checker.sv
testbench/core_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the core testbench, then scan the log
cd "$(dirname "$0")" || exit 1
log=sim.log
rm -rf obj_dir "$log"

verilator --binary --timing --assert -f vlog.f --top-module core_tb -o core_sim \
  && ./obj_dir/core_sim > "$log" 2>&1 \
  || { cat "$log" 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat "$log"
grep -q "test failed" "$log" && { echo "simulation reported a failure"; exit 1; } || exit 0
